//--- multicycle_cpu.f
+incdir+.
cpu_pkg.sv
alu.sv
imm_extend.sv
register_file.sv
pc_unit.sv
control_fsm.sv
datapath.sv
multicycle_cpu.sv
tb_multicycle_cpu.sv

//--- tb_program.svh
/*
 * Test program for the multicycle core and the stores it must make.
 * RV32I encoders, and a task that fills the program and store tables.
 */

`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ----------------------------------------
// RV32I instruction encoders.
// ----------------------------------------
function automatic instr_t rtype_word(input logic [6:0] f7, input funct3_t f3,
                                      input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_RTYPE};
endfunction

function automatic instr_t itype_word(input opcode_t op, input funct3_t f3,
                                      input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic instr_t stype_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic instr_t btype_word(input funct3_t f3, input int rs1, input int rs2,
                                      input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic instr_t jtype_word(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
endfunction

function automatic instr_t utype_word(input int rd, input int imm);
    return {imm[31:12], rd[4:0], OP_LUI};
endfunction

// SW of rs2 to an absolute address, with its expected store.
function automatic void add_store(input int rs2, input int addr, input data_t value);
    program_words.push_back(stype_word(rs2, 0, addr));
    store_addr.push_back(addr);
    store_data.push_back(value);
endfunction

// ----------------------------------------
// Program and expected stores.
// ----------------------------------------
task automatic build_program();
    int    rnd;
    data_t a;
    data_t b;
    data_t c;
    data_t sum;
    data_t diff;
    data_t upper;
    addr_t link;
    data_t logic_res [7];

    // Sign-extended 12-bit ADDI constants.
    rnd = $random(seed);
    a   = {{20{rnd[11]}}, rnd[11:0]};
    rnd = $random(seed);
    b   = {{20{rnd[11]}}, rnd[11:0]};
    rnd = $random(seed);
    c   = {{20{rnd[11]}}, rnd[11:0]};
    sum   = a + b;
    diff  = a - b;
    upper = 32'habcd_e000;

    // Arithmetic and LUI.
    program_words.push_back(itype_word(OP_ITYPE, F3_ADD_SUB, 1, 0, a));
    program_words.push_back(itype_word(OP_ITYPE, F3_ADD_SUB, 2, 0, b));
    program_words.push_back(rtype_word(7'h00, F3_ADD_SUB, 3, 1, 2));
    program_words.push_back(rtype_word(7'h20, F3_ADD_SUB, 4, 1, 2));
    program_words.push_back(utype_word(5, upper));
    add_store(1, 32'h100, a);
    add_store(3, 32'h104, sum);
    add_store(4, 32'h108, diff);
    add_store(5, 32'h10c, upper);

    // Logic ops and signed compare, x6 to x12.
    // The negative LUI value against zero tells signed from unsigned.
    program_words.push_back(rtype_word(7'h00, F3_AND, 6, 3, 4));
    program_words.push_back(rtype_word(7'h00, F3_OR, 7, 3, 4));
    program_words.push_back(rtype_word(7'h00, F3_XOR, 8, 3, 4));
    program_words.push_back(itype_word(OP_ITYPE, F3_AND, 9, 3, c));
    program_words.push_back(itype_word(OP_ITYPE, F3_OR, 10, 4, c));
    program_words.push_back(rtype_word(7'h00, F3_SLT, 11, 5, 0));
    program_words.push_back(rtype_word(7'h00, F3_SLT, 12, 1, 5));
    logic_res[0] = sum & diff;
    logic_res[1] = sum | diff;
    logic_res[2] = sum ^ diff;
    logic_res[3] = sum & c;
    logic_res[4] = diff | c;
    logic_res[5] = ($signed(upper) < 0) ? 32'd1 : 32'd0;
    logic_res[6] = ($signed(a) < $signed(upper)) ? 32'd1 : 32'd0;
    for (int k = 0; k < 7; k++) begin
        add_store(6 + k, 32'h110 + 4 * k, logic_res[k]);
    end

    // Load the sum back and store it again.
    program_words.push_back(itype_word(OP_LOAD, 3'b010, 13, 0, 32'h104));
    add_store(13, 32'h12c, sum);

    // Taken branches skip the store after them.
    program_words.push_back(btype_word(F3_BEQ, 1, 1, 8));
    program_words.push_back(stype_word(1, 0, 32'h130));
    program_words.push_back(btype_word(F3_BNE, 1, 1, 8));
    add_store(5, 32'h134, upper);
    program_words.push_back(btype_word(F3_BNE, 1, 5, 8));
    program_words.push_back(stype_word(1, 0, 32'h138));
    program_words.push_back(btype_word(F3_BEQ, 1, 5, 8));
    add_store(4, 32'h13c, diff);

    // JAL links the address after itself.
    link = 4 * program_words.size() + 4;
    program_words.push_back(jtype_word(14, 8));
    program_words.push_back(stype_word(1, 0, 32'h140));
    add_store(14, 32'h144, link);

    // x0 stays zero.
    program_words.push_back(itype_word(OP_ITYPE, F3_ADD_SUB, 0, 0, 32'h555));
    add_store(0, 32'h148, 32'h0);

    // End of program.
    program_words.push_back(jtype_word(0, 0));
endtask

`endif

//--- tb_multicycle_cpu.sv
/*
 * Testbench for the multicycle RV32I core.
 * Runs a fixed program from a word memory and checks every store.
 */

`timescale 1ns/1ps

module tb_multicycle_cpu
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int MEM_WORDS     = 256;
    localparam int RESET_CYCLES  = 2;
    localparam int MAX_CPI       = 5;
    localparam int SETTLE_CYCLES = 20;
    localparam int MARGIN_CYCLES = 50;

    logic   clk;
    logic   i_rst_n;
    addr_t  o_mem_addr;
    logic   o_mem_we;
    data_t  o_mem_wdata;
    data_t  i_mem_rdata;

    data_t  mem [MEM_WORDS];
    instr_t program_words [$];
    addr_t  store_addr [$];
    data_t  store_data [$];
    integer seed;
    longint timeout_ns = 0;

    `include "tb_program.svh"

    multicycle_cpu uut (
        .clk         ( clk         ),
        .i_rst_n     ( i_rst_n     ),
        .o_mem_addr  ( o_mem_addr  ),
        .o_mem_we    ( o_mem_we    ),
        .o_mem_wdata ( o_mem_wdata ),
        .i_mem_rdata ( i_mem_rdata )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Unified memory, combinational read.
    // ----------------------------------------
    assign i_mem_rdata = mem[o_mem_addr[9:2]];

    always @(posedge clk) begin
        if (o_mem_we) begin
            mem[o_mem_addr[9:2]] <= o_mem_wdata;
        end
    end

    // ----------------------------------------
    // Setup, reset and store checker.
    // ----------------------------------------
    initial begin
        i_rst_n = 1'b0;
        seed    = 32'hea27_24a7;
        build_program();
        // Fill word is unique per address.
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);
        end
        for (int i = 0; i < program_words.size(); i++) begin
            mem[i] = program_words[i];
        end
        timeout_ns = (program_words.size() * MAX_CPI + RESET_CYCLES + SETTLE_CYCLES
                      + MARGIN_CYCLES) * CLK_PERIOD;

        repeat (RESET_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;

        for (int n = 0; n < store_addr.size(); n++) begin
            do begin
                @(negedge clk);
            end while (!o_mem_we);
            assert (o_mem_addr == store_addr[n]) else begin
                $display("CHECK FAILED o_mem_addr store %0d expected %h actual %h",
                         n, store_addr[n], o_mem_addr);
                $display("Finished with errors");
                $fatal(1, "Store address mismatch.");
            end
            assert (o_mem_wdata == store_data[n]) else begin
                $display("CHECK FAILED o_mem_wdata store %0d expected %h actual %h",
                         n, store_data[n], o_mem_wdata);
                $display("Finished with errors");
                $fatal(1, "Store data mismatch.");
            end
        end

        // The closing self jump must not store again.
        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            assert (!o_mem_we) else begin
                $display("An extra store to address %h came after the last expected store.",
                         o_mem_addr);
                $display("Finished with errors");
                $fatal(1, "Unexpected store.");
            end
        end
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog.
    initial begin
        wait (timeout_ns != 0);
        #(timeout_ns);
        $display("Timeout after %0d ns: the expected stores did not all arrive.", timeout_ns);
        $display("Finished with errors");
        $fatal(1, "Simulation timed out.");
    end

endmodule

//--- multicycle_cpu.sv
/*
 * Multicycle RV32I subset core.
 * Connects the control FSM, the program counter and the datapath
 * to one unified memory port.
 */

`timescale 1ns/1ps

module multicycle_cpu
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    output addr_t o_mem_addr,
    output logic  o_mem_we,
    output data_t o_mem_wdata,
    input  data_t i_mem_rdata
);

    // ----------------------------------------
    // Internal nets.
    // ----------------------------------------

    // Control strobes and selects.
    logic        s_ir_we;
    logic        s_pc_inc;
    logic        s_pc_load;
    logic        s_reg_we;
    logic        s_mdr_we;
    logic        s_addr_sel;
    alu_op_e     s_alu_op;
    src_a_sel_e  s_src_a;
    src_b_sel_e  s_src_b;
    imm_sel_e    s_imm_sel;
    result_sel_e s_result_sel;

    // Status back to the FSM.
    opcode_t s_opcode;
    funct3_t s_funct3;
    logic    s_funct7_b5;
    logic    s_zero;

    // Program counter values.
    addr_t s_pc;
    addr_t s_old_pc;
    addr_t s_alu_reg;

    control_fsm ctrl (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_opcode     ( s_opcode     ),
        .i_funct3     ( s_funct3     ),
        .i_funct7_b5  ( s_funct7_b5  ),
        .i_zero       ( s_zero       ),
        .o_ir_we      ( s_ir_we      ),
        .o_pc_inc     ( s_pc_inc     ),
        .o_pc_load    ( s_pc_load    ),
        .o_reg_we     ( s_reg_we     ),
        .o_mdr_we     ( s_mdr_we     ),
        .o_mem_we     ( o_mem_we     ),
        .o_addr_sel   ( s_addr_sel   ),
        .o_alu_op     ( s_alu_op     ),
        .o_src_a      ( s_src_a      ),
        .o_src_b      ( s_src_b      ),
        .o_imm_sel    ( s_imm_sel    ),
        .o_result_sel ( s_result_sel )
    );

    pc_unit pcu (
        .clk       ( clk       ),
        .i_rst_n   ( i_rst_n   ),
        .i_pc_inc  ( s_pc_inc  ),
        .i_pc_load ( s_pc_load ),
        .i_target  ( s_alu_reg ),
        .o_pc      ( s_pc      ),
        .o_old_pc  ( s_old_pc  )
    );

    datapath dpath (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_ir_we      ( s_ir_we      ),
        .i_reg_we     ( s_reg_we     ),
        .i_mdr_we     ( s_mdr_we     ),
        .i_addr_sel   ( s_addr_sel   ),
        .i_alu_op     ( s_alu_op     ),
        .i_src_a      ( s_src_a      ),
        .i_src_b      ( s_src_b      ),
        .i_imm_sel    ( s_imm_sel    ),
        .i_result_sel ( s_result_sel ),
        .i_pc         ( s_pc         ),
        .i_old_pc     ( s_old_pc     ),
        .i_mem_rdata  ( i_mem_rdata  ),
        .o_opcode     ( s_opcode     ),
        .o_funct3     ( s_funct3     ),
        .o_funct7_b5  ( s_funct7_b5  ),
        .o_zero       ( s_zero       ),
        .o_alu_reg    ( s_alu_reg    ),
        .o_mem_addr   ( o_mem_addr   ),
        .o_mem_wdata  ( o_mem_wdata  )
    );

endmodule

//--- datapath.sv
/*
 * Datapath of the multicycle core.
 * Instruction and holding registers, ALU operand and write-back
 * multiplexers, and the memory address select.
 */

`timescale 1ns/1ps

module datapath
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_ir_we,
    input  logic        i_reg_we,
    input  logic        i_mdr_we,
    input  logic        i_addr_sel,
    input  alu_op_e     i_alu_op,
    input  src_a_sel_e  i_src_a,
    input  src_b_sel_e  i_src_b,
    input  imm_sel_e    i_imm_sel,
    input  result_sel_e i_result_sel,
    input  addr_t       i_pc,
    input  addr_t       i_old_pc,
    input  data_t       i_mem_rdata,
    output opcode_t     o_opcode,
    output funct3_t     o_funct3,
    output logic        o_funct7_b5,
    output logic        o_zero,
    output addr_t       o_alu_reg,
    output addr_t       o_mem_addr,
    output data_t       o_mem_wdata
);

    // Holding registers.
    instr_t s_reg_instr;
    data_t  s_reg_data_1;
    data_t  s_reg_data_2;
    data_t  s_reg_alu_result;
    data_t  s_reg_mem_data;

    // Register file, immediate and ALU nets.
    reg_addr_t s_rs1;
    reg_addr_t s_rs2;
    reg_addr_t s_rd;
    data_t     s_read_data_1;
    data_t     s_read_data_2;
    data_t     s_imm;
    data_t     s_alu_a;
    data_t     s_alu_b;
    data_t     s_alu_result;
    data_t     s_result;

    // Instruction fields.
    assign s_rs1       = s_reg_instr[19:15];
    assign s_rs2       = s_reg_instr[24:20];
    assign s_rd        = s_reg_instr[11:7];
    assign o_opcode    = s_reg_instr[6:0];
    assign o_funct3    = s_reg_instr[14:12];
    assign o_funct7_b5 = s_reg_instr[30];

    // ----------------------------------------
    // Instruction and holding registers.
    // ----------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_reg_instr <= '0;
        end else if (i_ir_we) begin
            s_reg_instr <= i_mem_rdata;
        end
    end

    // Operand latches and ALU result load every cycle.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_reg_data_1     <= '0;
            s_reg_data_2     <= '0;
            s_reg_alu_result <= '0;
            s_reg_mem_data   <= '0;
        end else begin
            s_reg_data_1     <= s_read_data_1;
            s_reg_data_2     <= s_read_data_2;
            s_reg_alu_result <= s_alu_result;
            if (i_mdr_we) begin
                s_reg_mem_data <= i_mem_rdata;
            end
        end
    end

    // ----------------------------------------
    // Multiplexers.
    // ----------------------------------------
    assign s_alu_a = (i_src_a == SRC_A_OLD_PC) ? i_old_pc : s_reg_data_1;
    assign s_alu_b = (i_src_b == SRC_B_IMM) ? s_imm : s_reg_data_2;

    always_comb begin
        case (i_result_sel)
            RES_MEM_DATA: s_result = s_reg_mem_data;
            RES_PC:       s_result = i_pc;
            RES_IMM:      s_result = s_imm;
            default:      s_result = s_reg_alu_result;
        endcase
    end

    assign o_alu_reg   = s_reg_alu_result;
    assign o_mem_addr  = i_addr_sel ? s_reg_alu_result : i_pc;
    assign o_mem_wdata = s_reg_data_2;

    register_file reg_file (
        .clk       ( clk           ),
        .i_rst_n   ( i_rst_n       ),
        .i_we      ( i_reg_we      ),
        .i_addr_1  ( s_rs1         ),
        .i_addr_2  ( s_rs2         ),
        .i_addr_3  ( s_rd          ),
        .i_wdata   ( s_result      ),
        .o_rdata_1 ( s_read_data_1 ),
        .o_rdata_2 ( s_read_data_2 )
    );

    alu alu_inst (
        .i_alu_op ( i_alu_op     ),
        .i_src_a  ( s_alu_a      ),
        .i_src_b  ( s_alu_b      ),
        .o_result ( s_alu_result ),
        .o_zero   ( o_zero       )
    );

    imm_extend imm_ext (
        .i_instr   ( s_reg_instr ),
        .i_imm_sel ( i_imm_sel   ),
        .o_imm     ( s_imm       )
    );

endmodule

//--- control_fsm.sv
/*
 * Control FSM of the multicycle core.
 * Walks each instruction through its states and drives every
 * datapath strobe and select as a Moore output.
 */

`timescale 1ns/1ps

module control_fsm
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  opcode_t     i_opcode,
    input  funct3_t     i_funct3,
    input  logic        i_funct7_b5,
    input  logic        i_zero,
    output logic        o_ir_we,
    output logic        o_pc_inc,
    output logic        o_pc_load,
    output logic        o_reg_we,
    output logic        o_mdr_we,
    output logic        o_mem_we,
    output logic        o_addr_sel,
    output alu_op_e     o_alu_op,
    output src_a_sel_e  o_src_a,
    output src_b_sel_e  o_src_b,
    output imm_sel_e    o_imm_sel,
    output result_sel_e o_result_sel
);

    state_e  s_state;
    state_e  s_next_state;
    alu_op_e s_funct_op;
    logic    s_branch_taken;

    // ----------------------------------------
    // State register.
    // ----------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s_state <= S_FETCH;
        end else begin
            s_state <= s_next_state;
        end
    end

    // ALU operation from funct fields. SUB exists only for R-type.
    always_comb begin
        case (i_funct3)
            F3_ADD_SUB: s_funct_op = (i_opcode == OP_RTYPE && i_funct7_b5) ? ALU_SUB : ALU_ADD;
            F3_SLT:     s_funct_op = ALU_SLT;
            F3_XOR:     s_funct_op = ALU_XOR;
            F3_OR:      s_funct_op = ALU_OR;
            F3_AND:     s_funct_op = ALU_AND;
            default:    s_funct_op = ALU_ADD;
        endcase
    end

    // Branch sense.
    always_comb begin
        case (i_funct3)
            F3_BEQ:  s_branch_taken = i_zero;
            F3_BNE:  s_branch_taken = !i_zero;
            default: s_branch_taken = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Next state and outputs.
    // ----------------------------------------
    always_comb begin
        s_next_state = S_FETCH;
        o_ir_we      = 1'b0;
        o_pc_inc     = 1'b0;
        o_pc_load    = 1'b0;
        o_reg_we     = 1'b0;
        o_mdr_we     = 1'b0;
        o_mem_we     = 1'b0;
        o_addr_sel   = 1'b0;
        o_alu_op     = ALU_ADD;
        o_src_a      = SRC_A_RS1;
        o_src_b      = SRC_B_RS2;
        o_imm_sel    = IMM_I;
        o_result_sel = RES_ALU_REG;

        case (s_state)
            S_FETCH: begin
                o_ir_we      = 1'b1;
                o_pc_inc     = 1'b1;
                s_next_state = S_DECODE;
            end
            S_DECODE: begin
                // Branch or jump target, computed ahead of time.
                o_src_a   = SRC_A_OLD_PC;
                o_src_b   = SRC_B_IMM;
                o_imm_sel = (i_opcode == OP_JAL) ? IMM_J : IMM_B;
                case (i_opcode)
                    OP_RTYPE:             s_next_state = S_EXEC_R;
                    OP_ITYPE:             s_next_state = S_EXEC_I;
                    OP_LOAD, OP_STORE:    s_next_state = S_MEM_ADDR;
                    OP_BRANCH:            s_next_state = S_BRANCH;
                    OP_JAL:               s_next_state = S_JUMP;
                    OP_LUI:               s_next_state = S_ALU_WB;
                    default:              s_next_state = S_FETCH;
                endcase
            end
            S_EXEC_R: begin
                o_alu_op     = s_funct_op;
                s_next_state = S_ALU_WB;
            end
            S_EXEC_I: begin
                o_alu_op     = s_funct_op;
                o_src_b      = SRC_B_IMM;
                s_next_state = S_ALU_WB;
            end
            S_MEM_ADDR: begin
                o_src_b      = SRC_B_IMM;
                o_imm_sel    = (i_opcode == OP_STORE) ? IMM_S : IMM_I;
                s_next_state = (i_opcode == OP_STORE) ? S_MEM_WRITE : S_MEM_READ;
            end
            S_MEM_READ: begin
                o_addr_sel   = 1'b1;
                o_mdr_we     = 1'b1;
                s_next_state = S_MEM_WB;
            end
            S_MEM_WB: begin
                o_reg_we     = 1'b1;
                o_result_sel = RES_MEM_DATA;
            end
            S_MEM_WRITE: begin
                o_addr_sel = 1'b1;
                o_mem_we   = 1'b1;
            end
            S_ALU_WB: begin
                // LUI writes the U immediate straight through.
                o_reg_we     = 1'b1;
                o_imm_sel    = IMM_U;
                o_result_sel = (i_opcode == OP_LUI) ? RES_IMM : RES_ALU_REG;
            end
            S_BRANCH: begin
                o_alu_op  = ALU_SUB;
                o_pc_load = s_branch_taken;
            end
            S_JUMP: begin
                o_reg_we     = 1'b1;
                o_result_sel = RES_PC;
                o_pc_load    = 1'b1;
            end
            default: s_next_state = S_FETCH;
        endcase
    end

endmodule

//--- pc_unit.sv
/*
 * Program counter with its old-PC copy.
 * Steps by four on increment and loads the target on load.
 */

`timescale 1ns/1ps

module pc_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_pc_inc,
    input  logic  i_pc_load,
    input  addr_t i_target,
    output addr_t o_pc,
    output addr_t o_old_pc
);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc     <= RESET_PC;
            o_old_pc <= RESET_PC;
        end else begin
            // Load has priority over increment.
            if (i_pc_load) begin
                o_pc <= i_target;
            end else if (i_pc_inc) begin
                o_pc <= o_pc + PC_STEP;
            end

            // Address of the instruction being fetched.
            if (i_pc_inc) begin
                o_old_pc <= o_pc;
            end
        end
    end

endmodule

//--- register_file.sv
/*
 * Register file with two asynchronous read ports and one
 * synchronous write port. Register zero always reads zero.
 */

`timescale 1ns/1ps

module register_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_we,
    input  reg_addr_t i_addr_1,
    input  reg_addr_t i_addr_2,
    input  reg_addr_t i_addr_3,
    input  data_t     i_wdata,
    output data_t     o_rdata_1,
    output data_t     o_rdata_2
);

    data_t s_regs [REG_COUNT];

    // Writes to x0 are dropped.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                s_regs[i] <= '0;
            end
        end else if (i_we && (i_addr_3 != '0)) begin
            s_regs[i_addr_3] <= i_wdata;
        end
    end

    assign o_rdata_1 = s_regs[i_addr_1];
    assign o_rdata_2 = s_regs[i_addr_2];

endmodule

//--- imm_extend.sv
/*
 * Immediate extender.
 * Builds sign-extended I, S, B and J immediates and the U immediate.
 */

`timescale 1ns/1ps

module imm_extend
    import cpu_pkg::*;
(
    input  instr_t   i_instr,
    input  imm_sel_e i_imm_sel,
    output data_t    o_imm
);

    always_comb begin
        case (i_imm_sel)
            IMM_S: o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B: o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                            i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_J: o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                            i_instr[20], i_instr[30:21], 1'b0};
            // Upper 20 bits, low bits zero.
            IMM_U: o_imm = {i_instr[31:12], 12'b0};
            default: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

//--- alu.sv
/*
 * Arithmetic and logic unit.
 * ADD, SUB, AND, OR, XOR and signed SLT, with a zero flag.
 */

`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  alu_op_e i_alu_op,
    input  data_t   i_src_a,
    input  data_t   i_src_b,
    output data_t   o_result,
    output logic    o_zero
);

    logic s_less;

    // Signed compare for SLT.
    assign s_less = ($signed(i_src_a) < $signed(i_src_b));

    always_comb begin
        case (i_alu_op)
            ALU_ADD: o_result = i_src_a + i_src_b;
            ALU_SUB: o_result = i_src_a - i_src_b;
            ALU_AND: o_result = i_src_a & i_src_b;
            ALU_OR:  o_result = i_src_a | i_src_b;
            ALU_XOR: o_result = i_src_a ^ i_src_b;
            ALU_SLT: o_result = {{(XLEN-1){1'b0}}, s_less};
            default: o_result = i_src_a + i_src_b;
        endcase
    end

    // Branches compare through SUB.
    assign o_zero = (o_result == '0);

endmodule

//--- cpu_pkg.sv
/*
 * Shared definitions for the multicycle RV32I core.
 * Widths, opcode and funct3 codes, vector types and control enums.
 */

package cpu_pkg;

    // ----------------------------------------
    // Widths and sizes.
    // ----------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // Vector types.
    typedef logic [XLEN-1:0]       data_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [31:0]           instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;

    // Program counter.
    localparam addr_t PC_STEP  = addr_t'(4);
    localparam addr_t RESET_PC = '0;

    // ----------------------------------------
    // Opcodes of the supported subset.
    // ----------------------------------------
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_LUI    = 7'b0110111;

    // funct3 codes.
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    // ----------------------------------------
    // Control encodings.
    // ----------------------------------------
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_sel_e;

    typedef enum logic {SRC_A_RS1, SRC_A_OLD_PC} src_a_sel_e;

    typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_sel_e;

    typedef enum logic [1:0] {RES_ALU_REG, RES_MEM_DATA, RES_PC, RES_IMM} result_sel_e;

    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_EXEC_R, S_EXEC_I, S_MEM_ADDR, S_MEM_READ,
        S_MEM_WB, S_MEM_WRITE, S_ALU_WB, S_BRANCH, S_JUMP
    } state_e;

endpackage
